// ==== design/alu.sv ====
module alu (
  input  rv_pkg::xlen_t   a,
  input  rv_pkg::xlen_t   b,
  input  rv_pkg::alu_op_e op,
  output rv_pkg::xlen_t   y,
  output logic            zero,
  output logic            less,
  output logic            less_u
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  // Comparison flags, a against b
  assign zero = (a == b);
  assign less = ($signed(a) < $signed(b));
  assign less_u = (a < b);

  always_comb begin
    case (op)
      alu_add: y = a + b;
      alu_sub: y = a - b;
      alu_sll: y = a << shamt;
      alu_slt: y = {{(xlen - 1){1'b0}}, less};
      alu_sltu: y = {{(xlen - 1){1'b0}}, less_u};
      alu_xor: y = a ^ b;
      alu_srl: y = a >> shamt;
      alu_sra: y = $signed(a) >>> shamt;
      alu_or: y = a | b;
      alu_and: y = a & b;
      default: y = a + b;
    endcase
  end

endmodule

// ==== design/control_unit.sv ====
module control_unit (
  input  logic            clock,
  input  logic            rst,
  input  logic            wb_ack,
  input  logic [6:0]      opcode,
  input  logic [2:0]      funct3,
  input  logic            funct7_b5,
  input  logic            zero,
  input  logic            less,
  input  logic            less_u,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output logic [3:0]      wb_sel,
  output rv_pkg::alu_op_e alu_op,
  output logic            a_sel,
  output logic            b_sel,
  output logic            pc_en,
  output logic [1:0]      pc_src,
  output logic            ir_en,
  output logic            rd_en,
  output rv_pkg::rd_src_e rd_src,
  output logic            addr_src,
  output logic            halted,
  output logic            illegal
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_mem,
    st_halt
  } state_e;

  state_e state;
  state_e state_next;
  logic   mem_done;
  logic   bus_active;
  logic   ack;
  logic   exec;
  logic   taken;
  logic   is_mem;
  logic   exec_done;
  logic   rd_write;
  logic   supported;

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return alt ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= st_fetch;
      // Bus stays idle while reset is held
      mem_done <= 1'b1;
      illegal <= 1'b0;
    end else begin
      state <= state_next;
      mem_done <= (state == st_mem) && ack;
      if (exec && !supported) begin
        illegal <= 1'b1;
      end
    end
  end

  // One idle bus cycle between a data access and the next fetch
  assign bus_active = ((state == st_fetch) && !mem_done) || (state == st_mem);
  assign ack = bus_active && wb_ack;
  assign exec = (state == st_execute);

  assign wb_cyc = bus_active;
  assign wb_stb = bus_active;
  assign wb_we = (state == st_mem) && (opcode == op_store);
  assign wb_sel = 4'hf;

  always_comb begin
    case (funct3)
      3'b000: taken = zero;
      3'b001: taken = !zero;
      3'b100: taken = less;
      3'b101: taken = !less;
      3'b110: taken = less_u;
      3'b111: taken = !less_u;
      default: taken = 1'b0;
    endcase
  end

  // Decode depends only on the IR, enables below depend on state
  always_comb begin
    alu_op = alu_add;
    a_sel = 1'b0;
    b_sel = 1'b0;
    rd_src = rd_alu;
    pc_src = pc_sel_plus4;
    is_mem = 1'b0;
    exec_done = 1'b1;
    rd_write = 1'b1;
    supported = 1'b1;
    case (opcode)
      op_lui: rd_src = rd_imm;
      op_auipc: begin
        a_sel = 1'b1;
        b_sel = 1'b1;
      end
      op_jal: begin
        rd_src = rd_pc4;
        pc_src = pc_sel_target;
      end
      op_jalr: begin
        b_sel = 1'b1;
        rd_src = rd_pc4;
        pc_src = pc_sel_jalr;
      end
      op_branch: begin
        alu_op = alu_sub;
        rd_write = 1'b0;
        pc_src = taken ? pc_sel_target : pc_sel_plus4;
      end
      op_load, op_store: begin
        b_sel = 1'b1;
        rd_src = rd_mem;
        is_mem = 1'b1;
        exec_done = 1'b0;
        rd_write = 1'b0;
      end
      op_imm: begin
        b_sel = 1'b1;
        alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7_b5);
      end
      op_reg: alu_op = arith_op(funct3, funct7_b5);
      // ECALL stops the core
      op_system: begin
        exec_done = 1'b0;
        rd_write = 1'b0;
      end
      default: begin
        exec_done = 1'b0;
        rd_write = 1'b0;
        supported = 1'b0;
      end
    endcase
  end

  assign ir_en = (state == st_fetch) && ack;
  assign addr_src = (state == st_mem);
  assign pc_en = (exec && exec_done) || ((state == st_mem) && ack);
  assign rd_en = (exec && rd_write) || ((state == st_mem) && ack && (opcode == op_load));
  assign halted = (state == st_halt);

  always_comb begin
    state_next = state;
    case (state)
      st_fetch: begin
        if (ack) begin
          state_next = st_execute;
        end
      end
      st_execute: begin
        if (is_mem) begin
          state_next = st_mem;
        end else if (exec_done) begin
          state_next = st_fetch;
        end else begin
          state_next = st_halt;
        end
      end
      st_mem: begin
        if (ack) begin
          state_next = st_fetch;
        end
      end
      default: state_next = st_halt;
    endcase
  end

endmodule

// ==== design/dataflow.sv ====
module dataflow #(
  parameter rv_pkg::xlen_t reset_vector = '0
) (
  input  logic            clock,
  input  logic            rst,
  input  rv_pkg::xlen_t   wb_dat_r,
  input  rv_pkg::alu_op_e alu_op,
  input  logic            a_sel,
  input  logic            b_sel,
  input  logic            pc_en,
  input  logic [1:0]      pc_src,
  input  logic            ir_en,
  input  logic            rd_en,
  input  rv_pkg::rd_src_e rd_src,
  input  logic            addr_src,
  output rv_pkg::xlen_t   wb_adr,
  output rv_pkg::xlen_t   wb_dat_w,
  output logic [6:0]      opcode,
  output logic [2:0]      funct3,
  output logic            funct7_b5,
  output logic            zero,
  output logic            less,
  output logic            less_u
);
  import rv_pkg::*;

  xlen_t pc;
  xlen_t ir;
  xlen_t next_pc;
  xlen_t pc_plus4;
  xlen_t pc_target;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t rd_data;
  xlen_t imm;
  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_y;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= reset_vector;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

  // Instruction register loads on the fetch ack
  always_ff @(posedge clock) begin
    if (ir_en) begin
      ir <= wb_dat_r;
    end
  end

  register_file i_register_file (
    .clock   (clock),
    .rst     (rst),
    .wr_en   (rd_en),
    .rs1_addr(ir[19:15]),
    .rs2_addr(ir[24:20]),
    .rd_addr (ir[11:7]),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  imm_extender i_imm_extender (
    .instr(ir),
    .imm  (imm)
  );

  assign alu_a = a_sel ? pc : rs1_data;
  assign alu_b = b_sel ? imm : rs2_data;

  alu i_alu (
    .a     (alu_a),
    .b     (alu_b),
    .op    (alu_op),
    .y     (alu_y),
    .zero  (zero),
    .less  (less),
    .less_u(less_u)
  );

  assign pc_plus4 = pc + xlen_t'(4);
  assign pc_target = pc + imm;

  always_comb begin
    case (pc_src)
      pc_sel_target: next_pc = pc_target;
      // JALR clears bit 0 of the sum
      pc_sel_jalr: next_pc = {alu_y[xlen-1:1], 1'b0};
      default: next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    case (rd_src)
      rd_mem: rd_data = wb_dat_r;
      rd_pc4: rd_data = pc_plus4;
      rd_imm: rd_data = imm;
      default: rd_data = alu_y;
    endcase
  end

  assign wb_adr = addr_src ? alu_y : pc;
  assign wb_dat_w = rs2_data;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7_b5 = ir[30];

endmodule

// ==== design/imm_extender.sv ====
module imm_extender (
  input  rv_pkg::xlen_t instr,
  output rv_pkg::xlen_t imm
);
  import rv_pkg::*;

  logic [6:0] opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      // S format
      op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // B format, byte offset
      op_branch: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      // U format
      op_lui, op_auipc: imm = {instr[31:12], 12'b0};
      // J format, byte offset
      op_jal: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      // I format for everything else
      default: imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

// ==== design/register_file.sv ====
module register_file (
  input  logic          clock,
  input  logic          rst,
  input  logic          wr_en,
  input  logic [4:0]    rs1_addr,
  input  logic [4:0]    rs2_addr,
  input  logic [4:0]    rd_addr,
  input  rv_pkg::xlen_t rd_data,
  output rv_pkg::xlen_t rs1_data,
  output rv_pkg::xlen_t rs2_data
);
  import rv_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/rv_core.sv ====
module rv_core #(
  parameter rv_pkg::xlen_t reset_vector = '0
) (
  input  logic          clock,
  input  logic          rst,
  input  rv_pkg::xlen_t wb_dat_r,
  input  logic          wb_ack,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output rv_pkg::xlen_t wb_adr,
  output rv_pkg::xlen_t wb_dat_w,
  output logic [3:0]    wb_sel,
  output logic          halted,
  output logic          illegal
);
  import rv_pkg::*;

  alu_op_e    alu_op;
  rd_src_e    rd_src;
  logic       a_sel;
  logic       b_sel;
  logic       pc_en;
  logic [1:0] pc_src;
  logic       ir_en;
  logic       rd_en;
  logic       addr_src;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       zero;
  logic       less;
  logic       less_u;

  control_unit i_control_unit (
    .clock    (clock),
    .rst      (rst),
    .wb_ack   (wb_ack),
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7_b5(funct7_b5),
    .zero     (zero),
    .less     (less),
    .less_u   (less_u),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_sel   (wb_sel),
    .alu_op   (alu_op),
    .a_sel    (a_sel),
    .b_sel    (b_sel),
    .pc_en    (pc_en),
    .pc_src   (pc_src),
    .ir_en    (ir_en),
    .rd_en    (rd_en),
    .rd_src   (rd_src),
    .addr_src (addr_src),
    .halted   (halted),
    .illegal  (illegal)
  );

  dataflow #(
    .reset_vector(reset_vector)
  ) i_dataflow (
    .clock    (clock),
    .rst      (rst),
    .wb_dat_r (wb_dat_r),
    .alu_op   (alu_op),
    .a_sel    (a_sel),
    .b_sel    (b_sel),
    .pc_en    (pc_en),
    .pc_src   (pc_src),
    .ir_en    (ir_en),
    .rd_en    (rd_en),
    .rd_src   (rd_src),
    .addr_src (addr_src),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7_b5(funct7_b5),
    .zero     (zero),
    .less     (less),
    .less_u   (less_u)
  );

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

  // RV32I only, the word width is fixed
  localparam int xlen = 32;

  typedef logic [xlen-1:0] xlen_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Register writeback source
  typedef enum logic [1:0] {
    rd_alu,
    rd_mem,
    rd_pc4,
    rd_imm
  } rd_src_e;

  // Next PC select
  localparam logic [1:0] pc_sel_plus4 = 2'd0;
  localparam logic [1:0] pc_sel_target = 2'd1;
  localparam logic [1:0] pc_sel_jalr = 2'd2;

  // Major opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_core_tb -f rv_core.f -Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1

// ==== rv_core.f ====
design/rv_pkg.sv
design/alu.sv
design/imm_extender.sv
design/register_file.sv
design/dataflow.sv
design/control_unit.sv
design/rv_core.sv
verification/wb_memory_model.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_asserts.sv ====
module rv_core_asserts (
  input logic clock,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic wb_ack,
  input logic addr_src,
  input logic halted
);
  timeunit 1ns;
  timeprecision 1ps;

  stb_within_cyc: assert property (@(posedge clock) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("wb_stb high outside a bus cycle");

  // Address source and direction hold until the ack
  cycle_held: assert property (@(posedge clock) disable iff (rst)
    (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(addr_src) && $stable(wb_we)))
    else $error("Bus cycle changed or dropped before ack");

  halt_sticky: assert property (@(posedge clock) disable iff (rst) halted |=> halted)
    else $error("halted fell without reset");

endmodule

bind control_unit rv_core_asserts i_asserts (.*);

// ==== verification/rv_core_tb.sv ====
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam xlen_t reset_pc = 32'h0000_0000;
  localparam int result_word = 256;
  localparam int halt_limit = 3000;
  localparam xlen_t ecall_word = {25'd0, op_system};

  typedef struct {
    alu_op_e op;
    bit      use_imm;
    xlen_t   a;
    xlen_t   b;
  } alu_case_t;

  logic       clock;
  logic       rst;
  xlen_t      wb_dat_r;
  xlen_t      wb_adr;
  xlen_t      wb_dat_w;
  logic       wb_ack;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [3:0] wb_sel;
  logic       halted;
  logic       illegal;

  xlen_t      prog [$];
  alu_case_t  cases [$];
  int         mismatch_count;
  int         timeout_count;
  integer     seed = 32'h915b_cd8d;
  logic [2:0] branch_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  xlen_t      pair_a [4] = '{32'd5, 32'd5, 32'hffff_fffd, 32'h8000_0000};
  xlen_t      pair_b [4] = '{32'd5, 32'hffff_fffd, 32'd5, 32'd1};

  rv_core #(
    .reset_vector(reset_pc)
  ) i_dut (
    .clock   (clock),
    .rst     (rst),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_sel  (wb_sel),
    .halted  (halted),
    .illegal (illegal)
  );

  wb_memory_model i_mem (
    .clock(clock),
    .cyc  (wb_cyc),
    .stb  (wb_stb),
    .we   (wb_we),
    .adr  (wb_adr),
    .dat_w(wb_dat_w),
    .sel  (wb_sel),
    .dat_r(wb_dat_r),
    .ack  (wb_ack)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Instruction encoders
  function automatic xlen_t r_type(input logic alt, input logic [4:0] rs2, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic xlen_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic xlen_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic xlen_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic xlen_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [2:0] funct3_of(input alu_op_e op);
    case (op)
      alu_add, alu_sub: return 3'b000;
      alu_sll: return 3'b001;
      alu_slt: return 3'b010;
      alu_sltu: return 3'b011;
      alu_xor: return 3'b100;
      alu_srl, alu_sra: return 3'b101;
      alu_or: return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  // Reference model, RV32I rules
  function automatic xlen_t expected_result(input alu_op_e op, input xlen_t a, input xlen_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_sll: return a << sh;
      alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor: return a ^ b;
      alu_srl: return a >> sh;
      alu_sra: return xlen_t'($signed(a) >>> sh);
      alu_or: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Background word for unwritten memory, unique per address
  function automatic xlen_t fill_word(input int idx);
    return 32'h6b00_0000 | xlen_t'(idx * 4);
  endfunction

  task automatic emit(input xlen_t w);
    prog.push_back(w);
  endtask

  task automatic load_const(input logic [4:0] rd, input xlen_t value);
    xlen_t upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic load_program();
    for (int i = 0; i < 1024; i++) begin
      i_mem.mem[i] = fill_word(i);
    end
    foreach (prog[i]) begin
      i_mem.mem[i] = prog[i];
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    load_program();
    repeat (3) begin
      @(posedge clock);
      @(negedge clock);
      check_flag("wb_cyc", wb_cyc, 1'b0);
      check_flag("wb_stb", wb_stb, 1'b0);
      check_flag("wb_we", wb_we, 1'b0);
      check_flag("halted", halted, 1'b0);
      check_flag("illegal", illegal, 1'b0);
    end
    rst = 1'b0;
  endtask

  task automatic run_program(input bit expect_illegal);
    int cycles;
    apply_reset();
    cycles = 0;
    while (!wb_cyc && cycles < 20) begin
      @(negedge clock);
      cycles++;
    end
    if (!wb_cyc) begin
      timeout_count++;
      $display("Timeout: no bus cycle started after reset");
    end else begin
      check_word("wb_adr", wb_adr, reset_pc);
      check_sel("wb_sel", wb_sel, 4'hf);
    end
    cycles = 0;
    while (!halted && cycles < halt_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!halted) begin
      timeout_count++;
      $display("Timeout: core did not halt within %0d cycles", halt_limit);
    end else begin
      check_flag("illegal", illegal, expect_illegal);
      repeat (4) begin
        @(negedge clock);
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("halted", halted, 1'b1);
      end
    end
  endtask

  task automatic add_case(input alu_op_e op, input bit use_imm, input xlen_t a, input xlen_t b);
    alu_case_t c;
    c.op = op;
    c.use_imm = use_imm;
    c.a = a;
    c.b = b;
    cases.push_back(c);
  endtask

  task automatic run_alu_case(input alu_case_t c);
    xlen_t      b;
    xlen_t      imm;
    logic [2:0] f3;
    logic       alt;
    f3 = funct3_of(c.op);
    alt = (c.op == alu_sub) || (c.op == alu_sra);
    b = c.b;
    prog.delete();
    load_const(5'd1, c.a);
    if (c.use_imm) begin
      // Shift immediates carry a 5-bit amount
      if (f3 == 3'b001 || f3 == 3'b101) begin
        b = {27'd0, c.b[4:0]};
        imm = b;
        imm[10] = alt;
      end else begin
        b = {{20{c.b[11]}}, c.b[11:0]};
        imm = b;
      end
      emit(i_type(imm[11:0], 5'd1, f3, 5'd3, op_imm));
    end else begin
      load_const(5'd2, b);
      emit(r_type(alt, 5'd2, 5'd1, f3, 5'd3));
    end
    emit(s_type(12'h400, 5'd3, 5'd0));
    emit(ecall_word);
    run_program(1'b0);
    check_word($sformatf("mem[0x400] %s imm=%0d", c.op.name(), c.use_imm),
               i_mem.mem[result_word], expected_result(c.op, c.a, b));
  endtask

  task automatic run_memory_case();
    prog.delete();
    load_const(5'd5, 32'h8765_4321);
    emit(s_type(12'h400, 5'd5, 5'd0));
    emit(i_type(12'h400, 5'd0, 3'b010, 5'd6, op_load));
    emit(s_type(12'h404, 5'd6, 5'd0));
    // A write to x0 must be lost
    emit(i_type(12'h037, 5'd0, 3'b000, 5'd0, op_imm));
    emit(s_type(12'h408, 5'd0, 5'd0));
    emit(ecall_word);
    run_program(1'b0);
    check_word("mem[0x400]", i_mem.mem[result_word], 32'h8765_4321);
    check_word("mem[0x404]", i_mem.mem[result_word + 1], 32'h8765_4321);
    check_word("mem[0x408]", i_mem.mem[result_word + 2], 32'h0000_0000);
  endtask

  task automatic run_branch_case(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    xlen_t marker;
    marker = 32'h0bad_f00d;
    prog.delete();
    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd7, marker);
    // Taken branch skips the marker store
    emit(b_type(13'd8, 5'd2, 5'd1, f3));
    emit(s_type(12'h400, 5'd7, 5'd0));
    emit(ecall_word);
    run_program(1'b0);
    check_word($sformatf("mem[0x400] branch f3=%0d", f3), i_mem.mem[result_word],
               branch_taken(f3, a, b) ? fill_word(result_word) : marker);
  endtask

  task automatic run_jump_case();
    xlen_t jal_pc;
    xlen_t jalr_pc;
    xlen_t auipc_pc;
    prog.delete();
    jal_pc = xlen_t'(prog.size() * 4);
    emit(j_type(21'd12, 5'd1));
    // Padding words decode as illegal if a jump goes wrong
    emit(32'h0);
    emit(32'h0);
    emit(s_type(12'h400, 5'd1, 5'd0));
    emit(i_type(12'd37, 5'd0, 3'b000, 5'd2, op_imm));
    jalr_pc = xlen_t'(prog.size() * 4);
    emit(i_type(12'd0, 5'd2, 3'b000, 5'd3, op_jalr));
    emit(32'h0);
    emit(32'h0);
    emit(32'h0);
    emit(s_type(12'h404, 5'd3, 5'd0));
    auipc_pc = xlen_t'(prog.size() * 4);
    emit(u_type(20'h12345, 5'd4, op_auipc));
    emit(s_type(12'h408, 5'd4, 5'd0));
    emit(u_type(20'habcde, 5'd5, op_lui));
    emit(s_type(12'h40c, 5'd5, 5'd0));
    emit(ecall_word);
    run_program(1'b0);
    check_word("mem[0x400] jal link", i_mem.mem[result_word], jal_pc + 32'd4);
    check_word("mem[0x404] jalr link", i_mem.mem[result_word + 1], jalr_pc + 32'd4);
    check_word("mem[0x408] auipc", i_mem.mem[result_word + 2], auipc_pc + 32'h1234_5000);
    check_word("mem[0x40c] lui", i_mem.mem[result_word + 3], 32'habcd_e000);
  endtask

  task automatic run_illegal_case();
    prog.delete();
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd1, op_imm));
    emit(32'h0000_007f);
    run_program(1'b1);
  endtask

  initial begin
    alu_op_e op;
    xlen_t   a;
    xlen_t   b;
    rst = 1'b1;
    mismatch_count = 0;
    timeout_count = 0;

    // Corner rows
    add_case(alu_add, 1'b0, 32'h7fff_ffff, 32'h0000_0001);
    add_case(alu_sub, 1'b0, 32'h0000_0000, 32'h0000_0001);
    add_case(alu_sll, 1'b0, 32'h0000_0001, 32'h0000_003f);
    add_case(alu_slt, 1'b0, 32'hffff_ffff, 32'h0000_0001);
    add_case(alu_sltu, 1'b0, 32'hffff_ffff, 32'h0000_0001);
    add_case(alu_xor, 1'b0, 32'hf0f0_1234, 32'h0ff0_4321);
    add_case(alu_srl, 1'b0, 32'h8000_0000, 32'h0000_001f);
    add_case(alu_sra, 1'b0, 32'h8000_0000, 32'h0000_001f);
    add_case(alu_or, 1'b0, 32'h1200_0034, 32'h0056_7800);
    add_case(alu_and, 1'b0, 32'hffff_0000, 32'h00ff_ff00);
    add_case(alu_add, 1'b1, 32'h0000_0000, 32'h0000_0fff);
    add_case(alu_slt, 1'b1, 32'h0000_0000, 32'h0000_0800);
    add_case(alu_sltu, 1'b1, 32'h0000_0005, 32'h0000_0fff);
    add_case(alu_sra, 1'b1, 32'hf000_0000, 32'h0000_0004);
    add_case(alu_sll, 1'b1, 32'h0000_0003, 32'h0000_001e);
    for (int k = 0; k < 20; k++) begin
      op = alu_op_e'(4'(k % 10));
      a = $random(seed);
      b = $random(seed);
      add_case(op, (k >= 10) && (op != alu_sub), a, b);
    end

    foreach (cases[i]) begin
      run_alu_case(cases[i]);
    end
    run_memory_case();
    for (int f = 0; f < 6; f++) begin
      for (int p = 0; p < 4; p++) begin
        run_branch_case(branch_f3[f], pair_a[p], pair_b[p]);
      end
      a = $random(seed);
      b = $random(seed);
      run_branch_case(branch_f3[f], a, b);
    end
    run_jump_case();
    run_illegal_case();

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/wb_memory_model.sv ====
module wb_memory_model (
  input  logic          clock,
  input  logic          cyc,
  input  logic          stb,
  input  logic          we,
  input  rv_pkg::xlen_t adr,
  input  rv_pkg::xlen_t dat_w,
  input  logic [3:0]    sel,
  output rv_pkg::xlen_t dat_r,
  output logic          ack
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  // 1024 words, byte addressed through adr[11:2]
  xlen_t      mem [1024];
  logic [1:0] wait_cnt;
  xlen_t      draw;
  integer     seed = 32'h915b_cd8d;

  initial begin
    ack = 1'b0;
    dat_r = '0;
    wait_cnt = 2'd0;
  end

  // Slave outputs change on the falling edge, the core samples on the rising edge
  always @(negedge clock) begin
    if (ack) begin
      ack = 1'b0;
    end else if (cyc && stb) begin
      if (wait_cnt == 2'd0) begin
        if (we) begin
          for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
              mem[adr[11:2]][8*i +: 8] = dat_w[8*i +: 8];
            end
          end
        end
        dat_r = mem[adr[11:2]];
        ack = 1'b1;
        // Wait states for the next transfer
        draw = $random(seed);
        wait_cnt = draw[1:0];
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

endmodule
